//--- source/isa_pkg.sv
`default_nettype none

package isa_pkg;

        localparam int inst_w = 16;

        // Major opcode, bits 15 to 11
        typedef enum logic [4:0] {
                OP_ADDSP3   = 5'b00000,
                OP_NOP      = 5'b00001,
                OP_B        = 5'b00010,
                OP_BEQZ     = 5'b00100,
                OP_BNEZ     = 5'b00101,
                OP_SHIFT    = 5'b00110, // funct picks SLL, SRL, SRA
                OP_ADDIU3   = 5'b01000,
                OP_ADDIU    = 5'b01001,
                OP_GROUP_SP = 5'b01100, // rx field picks ADDSP, MTSP, SW_RS
                OP_LI       = 5'b01101,
                OP_LW_SP    = 5'b10010,
                OP_LW       = 5'b10011,
                OP_SW_SP    = 5'b11010,
                OP_SW       = 5'b11011,
                OP_ARITH    = 5'b11100,
                OP_LOGIC    = 5'b11101
        } opcode_e;

        typedef struct packed {
                opcode_e     op;
                logic [2:0]  rx;
                logic [7:0]  imm8;
        } rri_s;

        typedef struct packed {
                opcode_e     op;
                logic [2:0]  rx; // bits 10..8
                logic [2:0]  ry; // bits 7..5
                logic [2:0]  rz; // bits 4..2
                logic [1:0]  funct;
        } rrr_s;

        typedef struct packed {
                opcode_e     op;
                logic [10:0] imm11;
        } i11_s;

        typedef union packed {
                rri_s rri;
                rrr_s rrr;
                i11_s i11;
        } inst_u;

        typedef enum logic [4:0] {
                KIND_NOP, KIND_ADDIU, KIND_ADDIU3, KIND_ADDSP, KIND_ADDSP3,
                KIND_ADDU, KIND_SUBU, KIND_AND, KIND_OR,
                KIND_SLL, KIND_SRL, KIND_SRA, KIND_SLLV, KIND_LI,
                KIND_LW, KIND_LW_SP, KIND_SW, KIND_SW_SP, KIND_SW_RS,
                KIND_B, KIND_BEQZ, KIND_BNEZ, KIND_JR, KIND_MTSP
        } inst_kind_e;

endpackage

`default_nettype wire

//--- source/ctl_pkg.sv
`default_nettype none

package ctl_pkg;

        import isa_pkg::*;

        typedef enum logic [3:0] {
                ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL,
                ALU_SRL, ALU_SRA, ALU_SLLV, ALU_RETA, ALU_RETB
        } alu_op_e;

        typedef enum logic [1:0] {A_NOP, A_REGA, A_SP, A_RZ} a_sel_e;
        typedef enum logic [1:0] {B_NOP, B_REGB, B_IMM} b_sel_e;
        typedef enum logic [1:0] {DST_NOP, DST_REG, DST_SP} reg_dst_e;
        typedef enum logic [1:0] {WB_NOP, WB_ALU, WB_MEM} wb_src_e;
        typedef enum logic [1:0] {WA_NOP, WA_RX, WA_RY, WA_RZ} wb_addr_e;
        typedef enum logic [1:0] {JC_NEVER, JC_ALWAYS, JC_ZERO, JC_NONZERO} jump_cond_e;
        typedef enum logic [1:0] {JS_NOP, JS_IMM, JS_ALU} jump_src_e;
        typedef enum logic [1:0] {ST_NOP, ST_REGA, ST_REGB, ST_RA} store_src_e;

        typedef struct packed {
                alu_op_e            alu_op;
                a_sel_e             a_sel;
                b_sel_e             b_sel;
                reg_dst_e           reg_dst;
                wb_src_e            wb_src;
                wb_addr_e           wb_addr;
                logic               mem_en;
                logic               mem_wr; // 1 = store
                jump_cond_e         jump_cond;
                jump_src_e          jump_src;
                store_src_e         store_src;
                logic [inst_w-1:0]  imm;    // Already extended
        } ctl_word_s;

        // Bundle of an instruction that does nothing
        localparam ctl_word_s ctl_nop = '{
                alu_op:    ALU_NOP,
                a_sel:     A_NOP,
                b_sel:     B_NOP,
                reg_dst:   DST_NOP,
                wb_src:    WB_NOP,
                wb_addr:   WA_NOP,
                mem_en:    1'b0,
                mem_wr:    1'b0,
                jump_cond: JC_NEVER,
                jump_src:  JS_NOP,
                store_src: ST_NOP,
                imm:       '0
        };

endpackage

`default_nettype wire

//--- source/inst_classifier.sv
`timescale 1ns/10ps
`default_nettype none

module inst_classifier
        import isa_pkg::*;
(
        input  logic       clk_50MHz,
        input  logic       arst_n,
        input  logic       inst_valid,
        input  inst_u      inst,
        input  logic       accept,
        output logic       kind_valid,
        output inst_kind_e kind,
        output inst_u      kind_inst
);

        inst_kind_e kind_d;

        always_comb begin
                kind_d = KIND_NOP; // Unknown and dropped words
                case (inst.rrr.op)
                        OP_ADDSP3: kind_d = KIND_ADDSP3;
                        OP_B:      kind_d = KIND_B;
                        OP_BEQZ:   kind_d = KIND_BEQZ;
                        OP_BNEZ:   kind_d = KIND_BNEZ;
                        OP_ADDIU3: kind_d = KIND_ADDIU3;
                        OP_ADDIU:  kind_d = KIND_ADDIU;
                        OP_LI:     kind_d = KIND_LI;
                        OP_LW_SP:  kind_d = KIND_LW_SP;
                        OP_LW:     kind_d = KIND_LW;
                        OP_SW_SP:  kind_d = KIND_SW_SP;
                        OP_SW:     kind_d = KIND_SW;
                        OP_SHIFT: begin
                                case (inst.rrr.funct)
                                        2'b00: kind_d = KIND_SLL;
                                        2'b10: kind_d = KIND_SRL;
                                        2'b11: kind_d = KIND_SRA;
                                endcase
                        end
                        OP_GROUP_SP: begin
                                case (inst.rrr.rx)
                                        3'b011: kind_d = KIND_ADDSP;
                                        3'b100: kind_d = KIND_MTSP;
                                        3'b010: kind_d = KIND_SW_RS;
                                endcase
                        end
                        OP_ARITH: begin
                                case (inst.rrr.funct)
                                        2'b01: kind_d = KIND_ADDU;
                                        2'b11: kind_d = KIND_SUBU;
                                endcase
                        end
                        OP_LOGIC: begin
                                case ({inst.rrr.rz, inst.rrr.funct})
                                        5'b01100: kind_d = KIND_AND;
                                        5'b01101: kind_d = KIND_OR;
                                        5'b00100: kind_d = KIND_SLLV;
                                        5'b00000: if (inst.rrr.ry == 3'b000) kind_d = KIND_JR;
                                endcase
                        end
                endcase
        end

        always_ff @(posedge clk_50MHz or negedge arst_n) begin
                if (!arst_n)
                        kind_valid <= 1'b0;
                else
                        kind_valid <= accept;
        end

        // Payload follows any offered word, only accepted ones are marked valid
        always_ff @(posedge clk_50MHz) begin
                if (inst_valid) begin
                        kind      <= kind_d;
                        kind_inst <= inst;
                end
        end

endmodule

`default_nettype wire

//--- source/ctl_generator.sv
`timescale 1ns/10ps
`default_nettype none

module ctl_generator
        import isa_pkg::*, ctl_pkg::*;
(
        input  logic       clk_50MHz,
        input  logic       arst_n,
        input  logic       kind_valid,
        input  inst_kind_e kind,
        input  inst_u      kind_inst,
        output logic       ctl_valid,
        output ctl_word_s  ctl
);

        logic [inst_w-1:0] imm;
        ctl_word_s         ctl_d;

        always_comb begin
                case (kind)
                        KIND_ADDIU, KIND_ADDSP, KIND_ADDSP3, KIND_LW_SP,
                        KIND_SW_SP, KIND_SW_RS, KIND_BEQZ, KIND_BNEZ:
                                imm = {{8{kind_inst.rri.imm8[7]}}, kind_inst.rri.imm8};
                        KIND_ADDIU3:
                                imm = {{12{kind_inst.rrr.rz[1]}}, kind_inst.rrr.rz[1:0],
                                       kind_inst.rrr.funct};
                        KIND_LW, KIND_SW:
                                imm = {{11{kind_inst.rrr.rz[2]}}, kind_inst.rrr.rz,
                                       kind_inst.rrr.funct};
                        KIND_LI:
                                imm = {8'h00, kind_inst.rri.imm8};
                        KIND_B:
                                imm = {{5{kind_inst.i11.imm11[10]}}, kind_inst.i11.imm11};
                        default:
                                imm = '0;
                endcase
        end

        always_comb begin
                ctl_d = ctl_nop;
                case (kind)
                        KIND_ADDIU, KIND_ADDIU3, KIND_ADDSP3, KIND_LW, KIND_LW_SP: begin
                                ctl_d.alu_op  = ALU_ADD; // Base plus offset into a register
                                ctl_d.a_sel   = A_REGA;
                                ctl_d.b_sel   = B_IMM;
                                ctl_d.reg_dst = DST_REG;
                                ctl_d.wb_src  = WB_ALU;
                                ctl_d.wb_addr = WA_RX;
                                if (kind == KIND_ADDSP3 || kind == KIND_LW_SP)
                                        ctl_d.a_sel = A_SP;
                                if (kind == KIND_ADDIU3 || kind == KIND_LW)
                                        ctl_d.wb_addr = WA_RY;
                                if (kind == KIND_LW || kind == KIND_LW_SP) begin
                                        ctl_d.wb_src = WB_MEM;
                                        ctl_d.mem_en = 1'b1;
                                end
                        end
                        KIND_ADDSP: begin
                                ctl_d.alu_op  = ALU_ADD;
                                ctl_d.a_sel   = A_SP;
                                ctl_d.b_sel   = B_IMM;
                                ctl_d.reg_dst = DST_SP;
                                ctl_d.wb_src  = WB_ALU;
                        end
                        KIND_SW, KIND_SW_SP, KIND_SW_RS: begin
                                ctl_d.alu_op    = ALU_ADD;
                                ctl_d.a_sel     = (kind == KIND_SW) ? A_REGA : A_SP;
                                ctl_d.b_sel     = B_IMM;
                                ctl_d.mem_en    = 1'b1;
                                ctl_d.mem_wr    = 1'b1;
                                ctl_d.store_src = ST_REGA;
                                if (kind == KIND_SW)
                                        ctl_d.store_src = ST_REGB;
                                if (kind == KIND_SW_RS)
                                        ctl_d.store_src = ST_RA;
                        end
                        KIND_ADDU, KIND_SUBU, KIND_AND, KIND_OR, KIND_SLLV,
                        KIND_SLL, KIND_SRL, KIND_SRA: begin
                                ctl_d.a_sel   = A_REGA;
                                ctl_d.b_sel   = B_REGB;
                                ctl_d.reg_dst = DST_REG;
                                ctl_d.wb_src  = WB_ALU;
                                ctl_d.wb_addr = WA_RX;
                                case (kind)
                                        KIND_ADDU: ctl_d.alu_op = ALU_ADD;
                                        KIND_SUBU: ctl_d.alu_op = ALU_SUB;
                                        KIND_AND:  ctl_d.alu_op = ALU_AND;
                                        KIND_OR:   ctl_d.alu_op = ALU_OR;
                                        KIND_SLLV: ctl_d.alu_op = ALU_SLLV;
                                        KIND_SLL:  ctl_d.alu_op = ALU_SLL;
                                        KIND_SRL:  ctl_d.alu_op = ALU_SRL;
                                        default:   ctl_d.alu_op = ALU_SRA;
                                endcase
                                if (kind == KIND_ADDU || kind == KIND_SUBU)
                                        ctl_d.wb_addr = WA_RZ;
                                if (kind == KIND_SLLV)
                                        ctl_d.wb_addr = WA_RY;
                                // Shift amount comes from the rz field
                                if (kind == KIND_SLL || kind == KIND_SRL || kind == KIND_SRA)
                                        ctl_d.a_sel = A_RZ;
                        end
                        KIND_LI: begin
                                ctl_d.alu_op  = ALU_RETB;
                                ctl_d.b_sel   = B_IMM;
                                ctl_d.reg_dst = DST_REG;
                                ctl_d.wb_src  = WB_ALU;
                                ctl_d.wb_addr = WA_RX;
                        end
                        KIND_MTSP: begin
                                ctl_d.alu_op  = ALU_RETA;
                                ctl_d.a_sel   = A_REGA;
                                ctl_d.reg_dst = DST_SP;
                                ctl_d.wb_src  = WB_ALU;
                        end
                        KIND_B: begin
                                ctl_d.jump_cond = JC_ALWAYS;
                                ctl_d.jump_src  = JS_IMM;
                        end
                        KIND_BEQZ, KIND_BNEZ: begin
                                ctl_d.a_sel     = A_REGA; // Tested register
                                ctl_d.jump_cond = (kind == KIND_BEQZ) ? JC_ZERO : JC_NONZERO;
                                ctl_d.jump_src  = JS_IMM;
                        end
                        KIND_JR: begin
                                ctl_d.alu_op    = ALU_RETA;
                                ctl_d.a_sel     = A_REGA;
                                ctl_d.jump_cond = JC_ALWAYS;
                                ctl_d.jump_src  = JS_ALU;
                        end
                        default: ;
                endcase
                ctl_d.imm = imm;
        end

        always_ff @(posedge clk_50MHz or negedge arst_n) begin
                if (!arst_n)
                        ctl_valid <= 1'b0;
                else
                        ctl_valid <= kind_valid;
        end

        always_ff @(posedge clk_50MHz) begin
                if (kind_valid)
                        ctl <= ctl_d;
        end

endmodule

`default_nettype wire

//--- source/credit_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module credit_tracker #(
        parameter int CREDITS = 2
) (
        input  logic clk_50MHz,
        input  logic arst_n,
        input  logic accept,
        input  logic ctl_credit,
        output logic inst_ready
);

        localparam int cnt_w = $clog2(CREDITS + 1);

        logic [cnt_w-1:0] count; // Free slots at the consumer

        always_ff @(posedge clk_50MHz or negedge arst_n) begin
                if (!arst_n) begin
                        count <= CREDITS[cnt_w-1:0];
                end else begin
                        case ({accept, ctl_credit})
                                2'b10:   count <= count - cnt_w'(1);
                                2'b01:   count <= count + cnt_w'(1);
                                default: count <= count; // Both or neither
                        endcase
                end
        end

        assign inst_ready = (count != '0);

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage
        import isa_pkg::*, ctl_pkg::*;
#(
        parameter int CREDITS = 2
) (
        input  logic      clk_50MHz,
        input  logic      arst_n,
        input  logic      inst_valid,
        input  inst_u     inst,
        input  logic      ctl_credit,
        output logic      inst_ready,
        output logic      ctl_valid,
        output ctl_word_s ctl
);

        logic       accept;
        logic       kind_valid;
        inst_kind_e kind;
        inst_u      kind_inst;

        assign accept = inst_valid & inst_ready;

        inst_classifier i_classifier (
                .clk_50MHz  (clk_50MHz),
                .arst_n     (arst_n),
                .inst_valid (inst_valid),
                .inst       (inst),
                .accept     (accept),
                .kind_valid (kind_valid),
                .kind       (kind),
                .kind_inst  (kind_inst)
        );

        ctl_generator i_generator (
                .clk_50MHz  (clk_50MHz),
                .arst_n     (arst_n),
                .kind_valid (kind_valid),
                .kind       (kind),
                .kind_inst  (kind_inst),
                .ctl_valid  (ctl_valid),
                .ctl        (ctl)
        );

        // Never more words in flight than the consumer can hold
        credit_tracker #(
                .CREDITS (CREDITS)
        ) i_credits (
                .clk_50MHz  (clk_50MHz),
                .arst_n     (arst_n),
                .accept     (accept),
                .ctl_credit (ctl_credit),
                .inst_ready (inst_ready)
        );

endmodule

`default_nettype wire

//--- tests/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// Columns: name, instruction word, then alu_op, a_sel, b_sel, reg_dst, wb_src,
// wb_addr, mem_en, mem_wr, jump_cond, jump_src, store_src, extended imm
task automatic load_vectors();
        add_vector("ADDIU neg imm8", 16'h4980, bundle(ALU_ADD, A_REGA, B_IMM, DST_REG, WB_ALU,
                   WA_RX, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'hff80));
        add_vector("ADDIU3", 16'h426d, bundle(ALU_ADD, A_REGA, B_IMM, DST_REG, WB_ALU,
                   WA_RY, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'hfffd));
        add_vector("ADDSP", 16'h6305, bundle(ALU_ADD, A_SP, B_IMM, DST_SP, WB_ALU,
                   WA_NOP, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h0005));
        add_vector("ADDSP3", 16'h047f, bundle(ALU_ADD, A_SP, B_IMM, DST_REG, WB_ALU,
                   WA_RX, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h007f));
        add_vector("ADDU", 16'he14d, bundle(ALU_ADD, A_REGA, B_REGB, DST_REG, WB_ALU,
                   WA_RZ, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h0000));
        add_vector("SUBU", 16'he14f, bundle(ALU_SUB, A_REGA, B_REGB, DST_REG, WB_ALU,
                   WA_RZ, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h0000));
        add_vector("AND", 16'he94c, bundle(ALU_AND, A_REGA, B_REGB, DST_REG, WB_ALU,
                   WA_RX, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h0000));
        add_vector("OR", 16'he94d, bundle(ALU_OR, A_REGA, B_REGB, DST_REG, WB_ALU,
                   WA_RX, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h0000));
        add_vector("SLLV", 16'he944, bundle(ALU_SLLV, A_REGA, B_REGB, DST_REG, WB_ALU,
                   WA_RY, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h0000));
        add_vector("SLL", 16'h314c, bundle(ALU_SLL, A_RZ, B_REGB, DST_REG, WB_ALU,
                   WA_RX, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h0000));
        add_vector("SRL", 16'h314e, bundle(ALU_SRL, A_RZ, B_REGB, DST_REG, WB_ALU,
                   WA_RX, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h0000));
        add_vector("SRA", 16'h314f, bundle(ALU_SRA, A_RZ, B_REGB, DST_REG, WB_ALU,
                   WA_RX, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h0000));
        add_vector("LI zero ext", 16'h6bf0, bundle(ALU_RETB, A_NOP, B_IMM, DST_REG, WB_ALU,
                   WA_RX, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h00f0));
        add_vector("MTSP", 16'h6440, bundle(ALU_RETA, A_REGA, B_NOP, DST_SP, WB_ALU,
                   WA_NOP, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h0000));
        add_vector("LW neg imm5", 16'h995e, bundle(ALU_ADD, A_REGA, B_IMM, DST_REG, WB_MEM,
                   WA_RY, 1'b1, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'hfffe));
        add_vector("LW_SP", 16'h9510, bundle(ALU_ADD, A_SP, B_IMM, DST_REG, WB_MEM,
                   WA_RX, 1'b1, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h0010));
        add_vector("SW", 16'hd945, bundle(ALU_ADD, A_REGA, B_IMM, DST_NOP, WB_NOP,
                   WA_NOP, 1'b1, 1'b1, JC_NEVER, JS_NOP, ST_REGB, 16'h0005));
        add_vector("SW_SP", 16'hd3ff, bundle(ALU_ADD, A_SP, B_IMM, DST_NOP, WB_NOP,
                   WA_NOP, 1'b1, 1'b1, JC_NEVER, JS_NOP, ST_REGA, 16'hffff));
        add_vector("SW_RS", 16'h6208, bundle(ALU_ADD, A_SP, B_IMM, DST_NOP, WB_NOP,
                   WA_NOP, 1'b1, 1'b1, JC_NEVER, JS_NOP, ST_RA, 16'h0008));
        add_vector("B pos", 16'h1123, bundle(ALU_NOP, A_NOP, B_NOP, DST_NOP, WB_NOP,
                   WA_NOP, 1'b0, 1'b0, JC_ALWAYS, JS_IMM, ST_NOP, 16'h0123));
        add_vector("B neg imm11", 16'h17fc, bundle(ALU_NOP, A_NOP, B_NOP, DST_NOP, WB_NOP,
                   WA_NOP, 1'b0, 1'b0, JC_ALWAYS, JS_IMM, ST_NOP, 16'hfffc));
        add_vector("BEQZ", 16'h22f0, bundle(ALU_NOP, A_REGA, B_NOP, DST_NOP, WB_NOP,
                   WA_NOP, 1'b0, 1'b0, JC_ZERO, JS_IMM, ST_NOP, 16'hfff0));
        add_vector("BNEZ", 16'h2b20, bundle(ALU_NOP, A_REGA, B_NOP, DST_NOP, WB_NOP,
                   WA_NOP, 1'b0, 1'b0, JC_NONZERO, JS_IMM, ST_NOP, 16'h0020));
        add_vector("JR", 16'hec00, bundle(ALU_RETA, A_REGA, B_NOP, DST_NOP, WB_NOP,
                   WA_NOP, 1'b0, 1'b0, JC_ALWAYS, JS_ALU, ST_NOP, 16'h0000));
        add_vector("NOP", 16'h0800, bundle(ALU_NOP, A_NOP, B_NOP, DST_NOP, WB_NOP,
                   WA_NOP, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h0000));
        add_vector("MFIH as NOP", 16'hf100, bundle(ALU_NOP, A_NOP, B_NOP, DST_NOP, WB_NOP,
                   WA_NOP, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h0000));
        add_vector("CMP as NOP", 16'he94a, bundle(ALU_NOP, A_NOP, B_NOP, DST_NOP, WB_NOP,
                   WA_NOP, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h0000));
        add_vector("unused opcode", 16'h3800, bundle(ALU_NOP, A_NOP, B_NOP, DST_NOP, WB_NOP,
                   WA_NOP, 1'b0, 1'b0, JC_NEVER, JS_NOP, ST_NOP, 16'h0000));
endtask

`endif

//--- tests/tb_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage
        import isa_pkg::*, ctl_pkg::*;
();

        logic      clk_50MHz;
        logic      arst_n;
        logic      inst_valid;
        inst_u     inst;
        logic      ctl_credit;
        logic      inst_ready;
        logic      ctl_valid;
        ctl_word_s ctl;

        string       vec_name[$];
        logic [15:0] vec_word[$];
        ctl_word_s   vec_exp[$];

        int exp_row[$];   // Accepted rows still in flight
        int exp_cycle[$];
        int cycle = 0;
        int cur_row = 0;
        int bundles_seen = 0;
        int credits_given = 0;
        int bundle_pass = 0;
        int bundle_fail = 0;
        int main_pass = 0;
        int main_fail = 0;
        bit hold_credits = 1'b0;
        bit fast_credits = 1'b0;
        bit timed_out = 1'b0;

        decode_stage i_dut (
                .clk_50MHz  (clk_50MHz),
                .arst_n     (arst_n),
                .inst_valid (inst_valid),
                .inst       (inst),
                .ctl_credit (ctl_credit),
                .inst_ready (inst_ready),
                .ctl_valid  (ctl_valid),
                .ctl        (ctl)
        );

        function automatic ctl_word_s bundle(input alu_op_e alu, input a_sel_e a,
                input b_sel_e b, input reg_dst_e dst, input wb_src_e wb, input wb_addr_e wa,
                input logic men, input logic mwr, input jump_cond_e jc, input jump_src_e js,
                input store_src_e st, input logic [15:0] imm);
                return '{alu, a, b, dst, wb, wa, men, mwr, jc, js, st, imm};
        endfunction

        task automatic add_vector(input string name, input logic [15:0] word,
                input ctl_word_s exp);
                vec_name.push_back(name);
                vec_word.push_back(word);
                vec_exp.push_back(exp);
        endtask

        `include "decode_vectors.svh"

        initial begin
                clk_50MHz = 1'b0;
                forever #20 clk_50MHz = ~clk_50MHz;
        end

        always @(posedge clk_50MHz) cycle <= cycle + 1;

        task automatic check_bundle();
                int row;
                int acc;
                bit ok;
                assert (exp_row.size() != 0) else begin
                        $display("Bundle arrived with no instruction in flight");
                        bundle_fail++;
                end
                if (exp_row.size() != 0) begin
                        row = exp_row.pop_front();
                        acc = exp_cycle.pop_front();
                        ok = 1'b1;
                        assert (ctl == vec_exp[row]) else begin
                                $display("Fail %s expected %h actual %h", vec_name[row],
                                         vec_exp[row], ctl);
                                ok = 1'b0;
                        end
                        assert (cycle == acc + 2) else begin
                                $display("Fail %s latency expected 2 actual %0d",
                                         vec_name[row], cycle - acc);
                                ok = 1'b0;
                        end
                        if (ok) begin
                                bundle_pass++;
                                $display("ok   %s", vec_name[row]);
                        end else begin
                                bundle_fail++;
                        end
                end
        endtask

        // Sampled mid cycle where DUT outputs are stable
        always @(negedge clk_50MHz) begin
                if (arst_n && inst_valid && inst_ready) begin
                        exp_row.push_back(cur_row);
                        exp_cycle.push_back(cycle);
                end
                if (ctl_valid) begin
                        bundles_seen++;
                        check_bundle();
                end
        end

        // One credit back per bundle seen
        initial begin : credit_return
                int wait_cnt;
                wait_cnt = 0;
                ctl_credit = 1'b0;
                forever begin
                        @(posedge clk_50MHz);
                        #2;
                        ctl_credit = 1'b0;
                        if (bundles_seen > credits_given && !hold_credits) begin
                                if (wait_cnt == 0 || fast_credits) begin
                                        ctl_credit = 1'b1;
                                        credits_given++;
                                        wait_cnt = $urandom_range(5, 0);
                                end else begin
                                        wait_cnt--;
                                end
                        end
                end
        end

        task automatic check_value(input string name, input int expected, input int actual);
                assert (actual == expected) else begin
                        $display("Fail %s expected %0d actual %0d", name, expected, actual);
                        main_fail++;
                end
                if (actual == expected) begin
                        main_pass++;
                        $display("ok   %s", name);
                end
        endtask

        // Called 2 ns after an edge, returns 2 ns after the accepting edge
        task automatic send_row(input int row);
                int waited;
                waited = 0;
                inst = vec_word[row];
                cur_row = row;
                inst_valid = 1'b1;
                @(negedge clk_50MHz);
                while (!inst_ready && waited < 20) begin
                        @(negedge clk_50MHz);
                        waited++;
                end
                if (!inst_ready) begin
                        $display("Timeout: inst_ready stayed low while sending %s", vec_name[row]);
                        timed_out = 1'b1;
                end
                @(posedge clk_50MHz);
                #2;
        endtask

        function automatic bit pipe_busy();
                return exp_row.size() != 0 || bundles_seen != credits_given || ctl_credit;
        endfunction

        task automatic wait_drained(input string what);
                int waited;
                waited = 0;
                @(negedge clk_50MHz);
                while (pipe_busy() && waited < 100) begin
                        @(negedge clk_50MHz);
                        waited++;
                end
                if (pipe_busy()) begin
                        $display("Timeout: pipeline did not drain %s", what);
                        timed_out = 1'b1;
                end
                @(posedge clk_50MHz);
                #2;
        endtask

        initial begin
                int accepted;
                int seen_before;
                void'($urandom(32'h3614_353e));
                arst_n = 1'b0;
                inst_valid = 1'b0;
                inst = '0;
                load_vectors();
                repeat (4) @(posedge clk_50MHz);
                @(negedge clk_50MHz);
                check_value("reset ctl_valid low", 0, int'(ctl_valid));
                check_value("reset inst_ready high", 1, int'(inst_ready));
                repeat (4) @(posedge clk_50MHz);
                #2 arst_n = 1'b1;
                @(negedge clk_50MHz);
                check_value("after reset ctl_valid low", 0, int'(ctl_valid));
                check_value("after reset inst_ready high", 1, int'(inst_ready));
                @(posedge clk_50MHz);
                #2;

                for (int r = 0; r < vec_name.size() && !timed_out; r++)
                        send_row(r);
                inst_valid = 1'b0;
                if (!timed_out)
                        wait_drained("after the table");

                // Consumer holds its credits, only two words may enter
                hold_credits = 1'b1;
                seen_before = bundles_seen;
                accepted = 0;
                cur_row = 0;
                inst = vec_word[0];
                inst_valid = !timed_out;
                for (int i = 0; i < 10 && !timed_out; i++) begin
                        @(negedge clk_50MHz);
                        if (inst_ready)
                                accepted++;
                        @(posedge clk_50MHz);
                        #2;
                        cur_row = accepted;
                        inst = vec_word[accepted];
                end
                inst_valid = 1'b0;
                if (!timed_out) begin
                        check_value("flow hold accepted", 2, accepted);
                        check_value("flow hold bundles", 2, bundles_seen - seen_before);
                        check_value("flow hold inst_ready low", 0, int'(inst_ready));
                end

                fast_credits = 1'b1; // Credits back right away
                hold_credits = 1'b0;
                for (int r = 2; r < 10 && !timed_out; r++)
                        send_row(r);
                inst_valid = 1'b0;
                if (!timed_out)
                        wait_drained("after the credit release");

                $display("Tests: %0d passed, %0d failed", bundle_pass + main_pass,
                         bundle_fail + main_fail);
                if (!timed_out && bundle_fail == 0 && main_fail == 0) begin
                        $display("ALL TESTS PASSED");
                end else begin
                        $display("SOME TESTS FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- all.f
+incdir+tests
source/isa_pkg.sv
source/ctl_pkg.sv
source/inst_classifier.sv
source/ctl_generator.sv
source/credit_tracker.sv
source/decode_stage.sv
tests/tb_decode_stage.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_decode_stage -f all.f -o tb_sim &&
        ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log && echo "Simulation passed" && exit 0 ||
        { echo "Simulation failed"; exit 1; }
